// ==== hdl/rn_reg_pkg.sv ====
package rn_reg_pkg;

  // ====================
  // Bus widths
  // ====================
  localparam int AXIL_ADDR_WIDTH = 12;
  localparam int AXIL_DATA_WIDTH = 32;

  // Register byte address
  typedef logic [AXIL_ADDR_WIDTH-1:0] reg_addr_t;
  // One register word
  typedef logic [AXIL_DATA_WIDTH-1:0] reg_data_t;
  // Full packet count, two register words wide
  typedef logic [2*AXIL_DATA_WIDTH-1:0] cnt_t;

  // ====================
  // Register map
  // ====================
  localparam reg_addr_t RN_VERSION_ADDR           = 12'h000;
  localparam reg_addr_t FATAL_ERR_ADDR            = 12'h004;
  // RoCEv2 counters, clearing pair then cumulative pair
  localparam reg_addr_t TRROCE_HIGH_ADDR          = 12'h008;
  localparam reg_addr_t TRROCE_LOW_ADDR           = 12'h00C;
  localparam reg_addr_t TRROCE_TOTAL_HIGH_ADDR    = 12'h010;
  localparam reg_addr_t TRROCE_TOTAL_LOW_ADDR     = 12'h014;
  // Non-RoCEv2 counters, same layout
  localparam reg_addr_t TRNONROCE_HIGH_ADDR       = 12'h018;
  localparam reg_addr_t TRNONROCE_LOW_ADDR        = 12'h01C;
  localparam reg_addr_t TRNONROCE_TOTAL_HIGH_ADDR = 12'h020;
  localparam reg_addr_t TRNONROCE_TOTAL_LOW_ADDR  = 12'h024;
  // Scratch register, the only writable one
  localparam reg_addr_t TEMPLATE_ADDR             = 12'h200;

  // ====================
  // Fixed values
  // ====================
  // Version as a DD/MM/YYYY date code
  localparam reg_data_t RN_VERSION_VALUE = 32'h11082022;
  // Returned for any unmapped read
  localparam reg_data_t DEFAULT_VALUE    = 32'hDEEDBEEF;
  // Every response is OKAY
  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;

  // ====================
  // Fatal-error layout
  // ====================
  // Bits [5:0] come straight from the fatal_err input
  localparam int FATAL_EXT_BITS              = 6;
  // Sticky overflow flags of the four counters
  localparam int FATAL_ROCE_OVF_BIT          = 6;
  localparam int FATAL_NONROCE_OVF_BIT       = 7;
  localparam int FATAL_ROCE_TOTAL_OVF_BIT    = 8;
  localparam int FATAL_NONROCE_TOTAL_OVF_BIT = 9;

endpackage

// ==== hdl/reg_access_if.sv ====
`timescale 1ns/1ps

interface reg_access_if
  import rn_reg_pkg::*;
();

  // Write side, strobe valid for one cycle
  logic      wr_en;
  reg_addr_t wr_addr;
  reg_data_t wr_data;

  // Read side, data returned in the same cycle as the strobe
  logic      rd_en;
  reg_addr_t rd_addr;
  reg_data_t rd_data;

  // Bus slave end
  modport bus (
    output wr_en, wr_addr, wr_data,
    output rd_en, rd_addr,
    input  rd_data
  );

  // Register file end
  modport regs (
    input  wr_en, wr_addr, wr_data,
    input  rd_en, rd_addr,
    output rd_data
  );

endinterface

// ==== hdl/axil_reg_slave.sv ====
`timescale 1ns/1ps

module axil_reg_slave
  import rn_reg_pkg::*;
(
  input  logic        axil_aclk,
  input  logic        axil_arstn,

  // Write address channel
  input  logic        awvalid,
  input  reg_addr_t   awaddr,
  output logic        awready,
  // Write data channel
  input  logic        wvalid,
  input  reg_data_t   wdata,
  output logic        wready,
  // Write response channel
  output logic        bvalid,
  output logic [1:0]  bresp,
  input  logic        bready,

  // Read address channel
  input  logic        arvalid,
  input  reg_addr_t   araddr,
  output logic        arready,
  // Read data channel
  output logic        rvalid,
  output reg_data_t   rdata,
  output logic [1:0]  rresp,
  input  logic        rready,

  // Register file side
  reg_access_if.bus   regs
);

  typedef enum logic [1:0]
  {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_t;

  typedef enum logic
  {
    RD_IDLE,
    RD_RESP
  } rd_state_t;

  wr_state_t wr_state;
  rd_state_t rd_state;
  // Address held between the AW and W handshakes
  reg_addr_t wr_addr_q;

  // ====================
  // Write channel
  // ====================
  // Ready and valid flags decode straight from the state
  assign awready = (wr_state == WR_IDLE);
  assign wready  = (wr_state == WR_DATA);
  assign bvalid  = (wr_state == WR_RESP);
  assign bresp   = AXI_RESP_OKAY;

  // Write lands in the register file on the W handshake edge
  assign regs.wr_en   = wvalid && wready;
  assign regs.wr_addr = wr_addr_q;
  assign regs.wr_data = wdata;

  always_ff @(posedge axil_aclk)
  begin
    if (!axil_arstn)
    begin
      wr_state <= WR_IDLE;
    end
    else
    begin
      case (wr_state)
        WR_IDLE:
        begin
          if (awvalid && awready)
          begin
            wr_state <= WR_DATA;
          end
        end
        WR_DATA:
        begin
          if (wvalid && wready)
          begin
            wr_state <= WR_RESP;
          end
        end
        WR_RESP:
        begin
          // Stay here under B back-pressure
          if (bvalid && bready)
          begin
            wr_state <= WR_IDLE;
          end
        end
        default:
        begin
          wr_state <= WR_IDLE;
        end
      endcase
    end
  end

  // Capture address on the AW handshake
  always_ff @(posedge axil_aclk)
  begin
    if (awvalid && awready)
    begin
      wr_addr_q <= awaddr;
    end
  end

  // ====================
  // Read channel
  // ====================
  assign arready = (rd_state == RD_IDLE);
  assign rvalid  = (rd_state == RD_RESP);
  assign rresp   = AXI_RESP_OKAY;

  // Read strobe also drives the clear-on-read logic
  assign regs.rd_en   = arvalid && arready;
  assign regs.rd_addr = araddr;

  always_ff @(posedge axil_aclk)
  begin
    if (!axil_arstn)
    begin
      rd_state <= RD_IDLE;
    end
    else
    begin
      case (rd_state)
        RD_IDLE:
        begin
          if (arvalid && arready)
          begin
            rd_state <= RD_RESP;
          end
        end
        RD_RESP:
        begin
          if (rvalid && rready)
          begin
            rd_state <= RD_IDLE;
          end
        end
        default:
        begin
          rd_state <= RD_IDLE;
        end
      endcase
    end
  end

  // Value before the edge, held until rready
  always_ff @(posedge axil_aclk)
  begin
    if (regs.rd_en)
    begin
      rdata <= regs.rd_data;
    end
  end

endmodule

// ==== hdl/pkt_stats.sv ====
`timescale 1ns/1ps

module pkt_stats
  import rn_reg_pkg::*;
(
  input  logic axil_aclk,
  input  logic axil_arstn,

  // One-cycle pulse per received packet
  input  logic pkt_recved,
  // Clear strobes from reads of the clearing pair
  input  logic clr_low,
  input  logic clr_high,

  output cnt_t clr_cnt,
  output cnt_t total_cnt,
  output logic clr_ovf,
  output logic total_ovf
);

  localparam int HALF = AXIL_DATA_WIDTH;

  cnt_t clr_next;
  cnt_t total_next;

  // ====================
  // Next counts
  // ====================
  always_comb
  begin
    clr_next   = clr_cnt + cnt_t'(pkt_recved);
    total_next = total_cnt + cnt_t'(pkt_recved);

    // Low clear restarts at the pulse of this cycle, no carry upward
    if (clr_low)
    begin
      clr_next[HALF-1:0]      = {{(HALF-1){1'b0}}, pkt_recved};
      clr_next[2*HALF-1:HALF] = clr_cnt[2*HALF-1:HALF];
    end

    if (clr_high)
    begin
      clr_next[2*HALF-1:HALF] = '0;
    end
  end

  // ====================
  // Clearing counter
  // ====================
  always_ff @(posedge axil_aclk)
  begin
    if (!axil_arstn)
    begin
      clr_cnt <= '0;
      clr_ovf <= 1'b0;
    end
    else
    begin
      // Sticky once the top bit is seen
      clr_ovf <= clr_ovf | clr_cnt[2*HALF-1];

      if (clr_ovf)
      begin
        // Frozen, high half kept for inspection
        clr_cnt[HALF-1:0] <= '0;
      end
      else
      begin
        clr_cnt <= clr_next;
      end
    end
  end

  // ====================
  // Cumulative counter
  // ====================
  // Same overflow rule, clears never reach it
  always_ff @(posedge axil_aclk)
  begin
    if (!axil_arstn)
    begin
      total_cnt <= '0;
      total_ovf <= 1'b0;
    end
    else
    begin
      total_ovf <= total_ovf | total_cnt[2*HALF-1];

      if (total_ovf)
      begin
        total_cnt[HALF-1:0] <= '0;
      end
      else
      begin
        total_cnt <= total_next;
      end
    end
  end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
  import rn_reg_pkg::*;
(
  input  logic       axil_aclk,
  input  logic       axil_arstn,

  input  logic       roce_pkt_recved,
  input  logic       non_roce_pkt_recved,
  input  reg_data_t  fatal_err,

  reg_access_if.regs regs
);

  localparam int HALF = AXIL_DATA_WIDTH;

  reg_data_t template_reg;
  reg_data_t fatal_err_reg;
  reg_data_t fatal_word;

  cnt_t roce_clr_cnt;
  cnt_t roce_total_cnt;
  cnt_t nonroce_clr_cnt;
  cnt_t nonroce_total_cnt;
  logic roce_clr_ovf;
  logic roce_total_ovf;
  logic nonroce_clr_ovf;
  logic nonroce_total_ovf;

  // ====================
  // Packet statistics
  // ====================
  // Clears fire once, on the read strobe of each half
  pkt_stats u_roce_stats (
    .axil_aclk  (axil_aclk),
    .axil_arstn (axil_arstn),
    .pkt_recved (roce_pkt_recved),
    .clr_low    (regs.rd_en && (regs.rd_addr == TRROCE_LOW_ADDR)),
    .clr_high   (regs.rd_en && (regs.rd_addr == TRROCE_HIGH_ADDR)),
    .clr_cnt    (roce_clr_cnt),
    .total_cnt  (roce_total_cnt),
    .clr_ovf    (roce_clr_ovf),
    .total_ovf  (roce_total_ovf)
  );

  pkt_stats u_nonroce_stats (
    .axil_aclk  (axil_aclk),
    .axil_arstn (axil_arstn),
    .pkt_recved (non_roce_pkt_recved),
    .clr_low    (regs.rd_en && (regs.rd_addr == TRNONROCE_LOW_ADDR)),
    .clr_high   (regs.rd_en && (regs.rd_addr == TRNONROCE_HIGH_ADDR)),
    .clr_cnt    (nonroce_clr_cnt),
    .total_cnt  (nonroce_total_cnt),
    .clr_ovf    (nonroce_clr_ovf),
    .total_ovf  (nonroce_total_ovf)
  );

  // ====================
  // Writable registers
  // ====================
  // Only the template takes writes, others drop silently
  always_ff @(posedge axil_aclk)
  begin
    if (!axil_arstn)
    begin
      template_reg <= '0;
    end
    else if (regs.wr_en && (regs.wr_addr == TEMPLATE_ADDR))
    begin
      template_reg <= regs.wr_data;
    end
  end

  // Fatal word, external bits low, overflow flags above, rest zero
  always_comb
  begin
    fatal_word                              = '0;
    fatal_word[FATAL_EXT_BITS-1:0]          = fatal_err[FATAL_EXT_BITS-1:0];
    fatal_word[FATAL_ROCE_OVF_BIT]          = roce_clr_ovf;
    fatal_word[FATAL_NONROCE_OVF_BIT]       = nonroce_clr_ovf;
    fatal_word[FATAL_ROCE_TOTAL_OVF_BIT]    = roce_total_ovf;
    fatal_word[FATAL_NONROCE_TOTAL_OVF_BIT] = nonroce_total_ovf;
  end

  // One cycle of sampling delay
  always_ff @(posedge axil_aclk)
  begin
    if (!axil_arstn)
    begin
      fatal_err_reg <= '0;
    end
    else
    begin
      fatal_err_reg <= fatal_word;
    end
  end

  // ====================
  // Read mux
  // ====================
  always_comb
  begin
    case (regs.rd_addr)
      RN_VERSION_ADDR:           regs.rd_data = RN_VERSION_VALUE;
      FATAL_ERR_ADDR:            regs.rd_data = fatal_err_reg;
      TRROCE_HIGH_ADDR:          regs.rd_data = roce_clr_cnt[2*HALF-1:HALF];
      TRROCE_LOW_ADDR:           regs.rd_data = roce_clr_cnt[HALF-1:0];
      TRROCE_TOTAL_HIGH_ADDR:    regs.rd_data = roce_total_cnt[2*HALF-1:HALF];
      TRROCE_TOTAL_LOW_ADDR:     regs.rd_data = roce_total_cnt[HALF-1:0];
      TRNONROCE_HIGH_ADDR:       regs.rd_data = nonroce_clr_cnt[2*HALF-1:HALF];
      TRNONROCE_LOW_ADDR:        regs.rd_data = nonroce_clr_cnt[HALF-1:0];
      TRNONROCE_TOTAL_HIGH_ADDR: regs.rd_data = nonroce_total_cnt[2*HALF-1:HALF];
      TRNONROCE_TOTAL_LOW_ADDR:  regs.rd_data = nonroce_total_cnt[HALF-1:0];
      TEMPLATE_ADDR:             regs.rd_data = template_reg;
      // Unmapped, old timer slots included
      default:                   regs.rd_data = DEFAULT_VALUE;
    endcase
  end

endmodule

// ==== hdl/rn_reg_control.sv ====
`timescale 1ns/1ps

module rn_reg_control
  import rn_reg_pkg::*;
(
  // AXI4-Lite register slave
  input  logic                       s_axil_reg_awvalid,
  input  logic [AXIL_ADDR_WIDTH-1:0] s_axil_reg_awaddr,
  output logic                       s_axil_reg_awready,
  input  logic                       s_axil_reg_wvalid,
  input  logic [AXIL_DATA_WIDTH-1:0] s_axil_reg_wdata,
  output logic                       s_axil_reg_wready,
  output logic                       s_axil_reg_bvalid,
  output logic [1:0]                 s_axil_reg_bresp,
  input  logic                       s_axil_reg_bready,
  input  logic                       s_axil_reg_arvalid,
  input  logic [AXIL_ADDR_WIDTH-1:0] s_axil_reg_araddr,
  output logic                       s_axil_reg_arready,
  output logic                       s_axil_reg_rvalid,
  output logic [AXIL_DATA_WIDTH-1:0] s_axil_reg_rdata,
  output logic [1:0]                 s_axil_reg_rresp,
  input  logic                       s_axil_reg_rready,

  // Packet statistics inputs
  input  logic                       roce_pkt_recved,
  input  logic                       non_roce_pkt_recved,
  input  logic [AXIL_DATA_WIDTH-1:0] fatal_err,

  input  logic                       axil_aclk,
  input  logic                       axil_arstn
);

  // Strobe link between bus FSMs and registers
  reg_access_if u_reg_access ();

  axil_reg_slave u_axil_reg_slave (
    .axil_aclk  (axil_aclk),
    .axil_arstn (axil_arstn),
    .awvalid    (s_axil_reg_awvalid),
    .awaddr     (s_axil_reg_awaddr),
    .awready    (s_axil_reg_awready),
    .wvalid     (s_axil_reg_wvalid),
    .wdata      (s_axil_reg_wdata),
    .wready     (s_axil_reg_wready),
    .bvalid     (s_axil_reg_bvalid),
    .bresp      (s_axil_reg_bresp),
    .bready     (s_axil_reg_bready),
    .arvalid    (s_axil_reg_arvalid),
    .araddr     (s_axil_reg_araddr),
    .arready    (s_axil_reg_arready),
    .rvalid     (s_axil_reg_rvalid),
    .rdata      (s_axil_reg_rdata),
    .rresp      (s_axil_reg_rresp),
    .rready     (s_axil_reg_rready),
    .regs       (u_reg_access.bus)
  );

  // Decode, counters and read mux
  reg_file u_reg_file (
    .axil_aclk           (axil_aclk),
    .axil_arstn          (axil_arstn),
    .roce_pkt_recved     (roce_pkt_recved),
    .non_roce_pkt_recved (non_roce_pkt_recved),
    .fatal_err           (fatal_err),
    .regs                (u_reg_access.regs)
  );

endmodule

// ==== test/rn_reg_control_chk.sv ====
`timescale 1ns/1ps

module rn_reg_control_chk
  import rn_reg_pkg::*;
(
  input logic                       axil_aclk,
  input logic                       axil_arstn,
  input logic                       s_axil_reg_awvalid,
  input logic                       s_axil_reg_awready,
  input logic                       s_axil_reg_bvalid,
  input logic                       s_axil_reg_bready,
  input logic                       s_axil_reg_arvalid,
  input logic                       s_axil_reg_arready,
  input logic                       s_axil_reg_rvalid,
  input logic                       s_axil_reg_rready,
  input logic [AXIL_DATA_WIDTH-1:0] s_axil_reg_rdata
);

  // Count of failed assertions
  int assert_failures = 0;

  // ====================
  // Response channels
  // ====================
  // B held until accepted
  bvalid_hold: assert property (@(posedge axil_aclk) disable iff (!axil_arstn)
    s_axil_reg_bvalid && !s_axil_reg_bready |=> s_axil_reg_bvalid)
  else
  begin
    $error("bvalid dropped before bready");
    assert_failures++;
  end

  // R held with stable data until accepted
  rvalid_hold: assert property (@(posedge axil_aclk) disable iff (!axil_arstn)
    s_axil_reg_rvalid && !s_axil_reg_rready |=> s_axil_reg_rvalid && $stable(s_axil_reg_rdata))
  else
  begin
    $error("rvalid or rdata changed before rready");
    assert_failures++;
  end

  // ====================
  // One transaction in flight
  // ====================
  // awready stays low from the AW handshake until B is accepted
  aw_b_excl: assert property (@(posedge axil_aclk) disable iff (!axil_arstn)
    (s_axil_reg_awvalid && s_axil_reg_awready) ||
    (!s_axil_reg_awready && !(s_axil_reg_bvalid && s_axil_reg_bready))
    |=> !s_axil_reg_awready)
  else
  begin
    $error("awready high while the write response is pending");
    assert_failures++;
  end

  // arready stays low from the AR handshake until R is accepted
  ar_r_excl: assert property (@(posedge axil_aclk) disable iff (!axil_arstn)
    (s_axil_reg_arvalid && s_axil_reg_arready) ||
    (!s_axil_reg_arready && !(s_axil_reg_rvalid && s_axil_reg_rready))
    |=> !s_axil_reg_arready)
  else
  begin
    $error("arready high while the read response is pending");
    assert_failures++;
  end

endmodule

bind rn_reg_control rn_reg_control_chk u_chk (
  .axil_aclk          (axil_aclk),
  .axil_arstn         (axil_arstn),
  .s_axil_reg_awvalid (s_axil_reg_awvalid),
  .s_axil_reg_awready (s_axil_reg_awready),
  .s_axil_reg_bvalid  (s_axil_reg_bvalid),
  .s_axil_reg_bready  (s_axil_reg_bready),
  .s_axil_reg_arvalid (s_axil_reg_arvalid),
  .s_axil_reg_arready (s_axil_reg_arready),
  .s_axil_reg_rvalid  (s_axil_reg_rvalid),
  .s_axil_reg_rready  (s_axil_reg_rready),
  .s_axil_reg_rdata   (s_axil_reg_rdata)
);

// ==== include/rn_tb_tasks.svh ====
`ifndef RN_TB_TASKS_SVH
`define RN_TB_TASKS_SVH

// Move to just after the next rising edge, where DUT outputs have settled
task automatic step_cycle();
  @(posedge axil_aclk);
  #DRIVE_DELAY;
endtask

// ====================
// AXI4-Lite write
// ====================
// AW and W raised together, W waits for wready
task automatic axil_write(input reg_addr_t addr, input reg_data_t data, input int hold);
  s_axil_reg_awvalid = 1'b1;
  s_axil_reg_awaddr  = addr;
  s_axil_reg_wvalid  = 1'b1;
  s_axil_reg_wdata   = data;
  s_axil_reg_bready  = 1'b0;
  while (!s_axil_reg_awready)
  begin
    step_cycle();
  end
  step_cycle();
  s_axil_reg_awvalid = 1'b0;
  while (!s_axil_reg_wready)
  begin
    step_cycle();
  end
  step_cycle();
  s_axil_reg_wvalid = 1'b0;
  while (!s_axil_reg_bvalid)
  begin
    step_cycle();
  end
  if (s_axil_reg_bresp !== AXI_RESP_OKAY)
    report_mismatch("s_axil_reg_bresp", 32'(s_axil_reg_bresp), 32'(AXI_RESP_OKAY));
  // B back-pressure, response must stay up
  repeat (hold)
  begin
    step_cycle();
    if (!s_axil_reg_bvalid)
      report_failure("bvalid dropped while bready was held low");
  end
  s_axil_reg_bready = 1'b1;
  step_cycle();
  s_axil_reg_bready = 1'b0;
  if (!s_axil_reg_awready)
    report_failure("awready did not return after the write response");
endtask

// ====================
// AXI4-Lite read
// ====================
// Address phase only, ends just after the AR handshake edge
task automatic read_start(input reg_addr_t addr);
  s_axil_reg_arvalid = 1'b1;
  s_axil_reg_araddr  = addr;
  s_axil_reg_rready  = 1'b0;
  while (!s_axil_reg_arready)
  begin
    step_cycle();
  end
  step_cycle();
  s_axil_reg_arvalid = 1'b0;
endtask

// Data phase, optionally with rready held low
task automatic read_finish(output reg_data_t data, input int hold);
  while (!s_axil_reg_rvalid)
  begin
    step_cycle();
  end
  data = s_axil_reg_rdata;
  if (s_axil_reg_rresp !== AXI_RESP_OKAY)
    report_mismatch("s_axil_reg_rresp", 32'(s_axil_reg_rresp), 32'(AXI_RESP_OKAY));
  repeat (hold)
  begin
    step_cycle();
    if (!s_axil_reg_rvalid)
      report_failure("rvalid dropped while rready was held low");
    if (s_axil_reg_rdata !== data)
      report_mismatch("s_axil_reg_rdata", s_axil_reg_rdata, data);
  end
  s_axil_reg_rready = 1'b1;
  step_cycle();
  s_axil_reg_rready = 1'b0;
  if (!s_axil_reg_arready)
    report_failure("arready did not return after the read response");
endtask

task automatic axil_read(input reg_addr_t addr, output reg_data_t data, input int hold);
  read_start(addr);
  read_finish(data, hold);
endtask

// ====================
// Packet pulses
// ====================
// RoCE on even slots, non-RoCE on odd slots, every pulse one cycle wide
task automatic pkt_pulses(input int n_roce, input int n_nonroce);
  int slots;
  slots = 2 * ((n_roce > n_nonroce) ? n_roce : n_nonroce);
  for (int j = 0; j < slots; j++)
  begin
    roce_pkt_recved     = (j % 2 == 0) && (j / 2 < n_roce);
    non_roce_pkt_recved = (j % 2 == 1) && (j / 2 < n_nonroce);
    if (roce_pkt_recved)
      model_count(0);
    if (non_roce_pkt_recved)
      model_count(1);
    step_cycle();
  end
  roce_pkt_recved     = 1'b0;
  non_roce_pkt_recved = 1'b0;
endtask

`endif

// ==== test/tb_rn_reg_control.sv ====
`timescale 1ns/1ps

module tb_rn_reg_control
  import rn_reg_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int DRIVE_DELAY  = 1;
  localparam int RESET_CYCLES = 3;
  localparam logic [15:0] LFSR_SEED = 16'd55;

  // Watchdog budget from the transaction counts and per-transaction bounds
  localparam int N_READS        = 40;
  localparam int READ_CYCLES    = 10;
  localparam int N_WRITES       = 6;
  localparam int WRITE_CYCLES   = 12;
  localparam int MAX_PULSES     = 2 * (32 + 16) + 4;
  localparam int MARGIN         = 200;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_READS * READ_CYCLES
                                + N_WRITES * WRITE_CYCLES + MAX_PULSES + MARGIN;

  logic      axil_aclk;
  logic      axil_arstn;
  logic      s_axil_reg_awvalid;
  reg_addr_t s_axil_reg_awaddr;
  logic      s_axil_reg_awready;
  logic      s_axil_reg_wvalid;
  reg_data_t s_axil_reg_wdata;
  logic      s_axil_reg_wready;
  logic      s_axil_reg_bvalid;
  logic [1:0] s_axil_reg_bresp;
  logic      s_axil_reg_bready;
  logic      s_axil_reg_arvalid;
  reg_addr_t s_axil_reg_araddr;
  logic      s_axil_reg_arready;
  logic      s_axil_reg_rvalid;
  reg_data_t s_axil_reg_rdata;
  logic [1:0] s_axil_reg_rresp;
  logic      s_axil_reg_rready;
  logic      roce_pkt_recved;
  logic      non_roce_pkt_recved;
  reg_data_t fatal_err;

  int mismatch_count;
  int failure_count;
  logic [15:0] lfsr;

  // Reference model, index 0 RoCE, index 1 non-RoCE
  cnt_t      exp_clr [2];
  cnt_t      exp_total [2];
  reg_data_t exp_template;
  reg_data_t exp_fatal;

  rn_reg_control u_rn_reg_control (
    .s_axil_reg_awvalid  (s_axil_reg_awvalid),
    .s_axil_reg_awaddr   (s_axil_reg_awaddr),
    .s_axil_reg_awready  (s_axil_reg_awready),
    .s_axil_reg_wvalid   (s_axil_reg_wvalid),
    .s_axil_reg_wdata    (s_axil_reg_wdata),
    .s_axil_reg_wready   (s_axil_reg_wready),
    .s_axil_reg_bvalid   (s_axil_reg_bvalid),
    .s_axil_reg_bresp    (s_axil_reg_bresp),
    .s_axil_reg_bready   (s_axil_reg_bready),
    .s_axil_reg_arvalid  (s_axil_reg_arvalid),
    .s_axil_reg_araddr   (s_axil_reg_araddr),
    .s_axil_reg_arready  (s_axil_reg_arready),
    .s_axil_reg_rvalid   (s_axil_reg_rvalid),
    .s_axil_reg_rdata    (s_axil_reg_rdata),
    .s_axil_reg_rresp    (s_axil_reg_rresp),
    .s_axil_reg_rready   (s_axil_reg_rready),
    .roce_pkt_recved     (roce_pkt_recved),
    .non_roce_pkt_recved (non_roce_pkt_recved),
    .fatal_err           (fatal_err),
    .axil_aclk           (axil_aclk),
    .axil_arstn          (axil_arstn)
  );

  // ====================
  // Reporting and stimulus helpers
  // ====================
  task automatic report_mismatch(input string name, input reg_data_t got, input reg_data_t exp);
    $display("CHECK FAILED: %s got 0x%08h expected 0x%08h", name, got, exp);
    mismatch_count++;
  endtask

  task automatic report_failure(input string what);
    $display("ERROR: %s", what);
    failure_count++;
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
  function automatic reg_data_t rand_bits(input int n);
    reg_data_t v;
    logic      fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // One packet seen by class c
  task automatic model_count(input int c);
    exp_clr[c]++;
    exp_total[c]++;
  endtask

  // Register map as seen from the bus
  function automatic reg_data_t expected_read(input reg_addr_t addr);
    case (addr)
      RN_VERSION_ADDR:           return RN_VERSION_VALUE;
      FATAL_ERR_ADDR:            return exp_fatal;
      TRROCE_HIGH_ADDR:          return exp_clr[0][63:32];
      TRROCE_LOW_ADDR:           return exp_clr[0][31:0];
      TRROCE_TOTAL_HIGH_ADDR:    return exp_total[0][63:32];
      TRROCE_TOTAL_LOW_ADDR:     return exp_total[0][31:0];
      TRNONROCE_HIGH_ADDR:       return exp_clr[1][63:32];
      TRNONROCE_LOW_ADDR:        return exp_clr[1][31:0];
      TRNONROCE_TOTAL_HIGH_ADDR: return exp_total[1][63:32];
      TRNONROCE_TOTAL_LOW_ADDR:  return exp_total[1][31:0];
      TEMPLATE_ADDR:             return exp_template;
      default:                   return DEFAULT_VALUE;
    endcase
  endfunction

  // Clear-on-read side effect of a read
  task automatic model_read_clear(input reg_addr_t addr);
    case (addr)
      TRROCE_LOW_ADDR:     exp_clr[0][31:0]  = '0;
      TRROCE_HIGH_ADDR:    exp_clr[0][63:32] = '0;
      TRNONROCE_LOW_ADDR:  exp_clr[1][31:0]  = '0;
      TRNONROCE_HIGH_ADDR: exp_clr[1][63:32] = '0;
      default:             ;
    endcase
  endtask

`include "rn_tb_tasks.svh"

  // Read one register and compare with the model
  task automatic read_check(input reg_addr_t addr, input string name, input int hold);
    reg_data_t exp;
    reg_data_t got;
    exp = expected_read(addr);
    axil_read(addr, got, hold);
    model_read_clear(addr);
    if (got !== exp)
      report_mismatch(name, got, exp);
  endtask

  task automatic read_all_stats();
    read_check(TRROCE_LOW_ADDR, "roce_low", 0);
    read_check(TRROCE_HIGH_ADDR, "roce_high", 0);
    read_check(TRROCE_TOTAL_LOW_ADDR, "roce_total_low", 0);
    read_check(TRROCE_TOTAL_HIGH_ADDR, "roce_total_high", 0);
    read_check(TRNONROCE_LOW_ADDR, "nonroce_low", 0);
    read_check(TRNONROCE_HIGH_ADDR, "nonroce_high", 0);
    read_check(TRNONROCE_TOTAL_LOW_ADDR, "nonroce_total_low", 0);
    read_check(TRNONROCE_TOTAL_HIGH_ADDR, "nonroce_total_high", 0);
  endtask

  // ====================
  // Tests
  // ====================
  task automatic test_reset_and_fixed();
    if (s_axil_reg_bvalid !== 1'b0)
      report_mismatch("s_axil_reg_bvalid", 32'(s_axil_reg_bvalid), 32'h0);
    if (s_axil_reg_wready !== 1'b0)
      report_mismatch("s_axil_reg_wready", 32'(s_axil_reg_wready), 32'h0);
    if (s_axil_reg_rvalid !== 1'b0)
      report_mismatch("s_axil_reg_rvalid", 32'(s_axil_reg_rvalid), 32'h0);
    if (s_axil_reg_awready !== 1'b1)
      report_mismatch("s_axil_reg_awready", 32'(s_axil_reg_awready), 32'h1);
    if (s_axil_reg_arready !== 1'b1)
      report_mismatch("s_axil_reg_arready", 32'(s_axil_reg_arready), 32'h1);
    read_check(RN_VERSION_ADDR, "version", 0);
    read_check(FATAL_ERR_ADDR, "fatal_err_reg", 0);
    read_all_stats();
    // Old timer slot and a hole in the map
    read_check(12'h028, "unmapped_028", 0);
    read_check(12'h100, "unmapped_100", 0);
  endtask

  task automatic test_template();
    reg_data_t data;
    data = rand_bits(32);
    axil_write(TEMPLATE_ADDR, data, 0);
    exp_template = data;
    read_check(TEMPLATE_ADDR, "template", 0);
    // Version is read-only
    axil_write(RN_VERSION_ADDR, rand_bits(32), 0);
    read_check(RN_VERSION_ADDR, "version_after_write", 0);
  endtask

  task automatic test_pkt_counting();
    int n;
    int m;
    n = 1 + int'(rand_bits(5));
    m = 1 + int'(rand_bits(5));
    pkt_pulses(n, m);
    read_all_stats();
  endtask

  task automatic test_clear_on_read();
    int        k;
    reg_data_t exp;
    reg_data_t got;
    // Lows were cleared by the previous reads, totals untouched
    read_check(TRROCE_LOW_ADDR, "roce_low_cleared", 0);
    read_check(TRNONROCE_LOW_ADDR, "nonroce_low_cleared", 0);
    read_check(TRROCE_TOTAL_LOW_ADDR, "roce_total_low", 0);
    read_check(TRNONROCE_TOTAL_LOW_ADDR, "nonroce_total_low", 0);
    k = 1 + int'(rand_bits(4));
    pkt_pulses(k, k);
    read_all_stats();
    // Pulse on the same edge as the clearing read handshake
    if (!s_axil_reg_arready)
      report_failure("arready low before the clear and pulse collision");
    exp = expected_read(TRROCE_LOW_ADDR);
    roce_pkt_recved = 1'b1;
    read_start(TRROCE_LOW_ADDR);
    roce_pkt_recved = 1'b0;
    read_finish(got, 0);
    model_read_clear(TRROCE_LOW_ADDR);
    model_count(0);
    if (got !== exp)
      report_mismatch("roce_low_collision", got, exp);
    read_check(TRROCE_LOW_ADDR, "roce_low_after_collision", 0);
    read_check(TRROCE_TOTAL_LOW_ADDR, "roce_total_after_collision", 0);
  endtask

  task automatic test_fatal_err();
    reg_data_t fe;
    fe        = rand_bits(32);
    fatal_err = fe;
    exp_fatal = fe & ((32'h1 << FATAL_EXT_BITS) - 1);
    // Register samples one cycle late
    step_cycle();
    step_cycle();
    read_check(FATAL_ERR_ADDR, "fatal_err_reg", 0);
  endtask

  task automatic test_back_pressure();
    reg_data_t data;
    data = rand_bits(32);
    axil_write(TEMPLATE_ADDR, data, 5);
    exp_template = data;
    read_check(TEMPLATE_ADDR, "template_held", 6);
    // Follow-up traffic after stalls
    data = rand_bits(32);
    axil_write(TEMPLATE_ADDR, data, 0);
    exp_template = data;
    read_check(TEMPLATE_ADDR, "template_after_stall", 0);
  endtask

  // ====================
  // Clock, watchdog, sequence
  // ====================
  initial
  begin
    axil_aclk = 1'b0;
    forever #(CLK_PERIOD / 2) axil_aclk = ~axil_aclk;
  end

  initial
  begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("ERROR: watchdog expired after %0d cycles, test sequence stalled", TIMEOUT_CYCLES);
    $display("Test failures found");
    $finish;
  end

  initial
  begin
    axil_arstn          = 1'b0;
    s_axil_reg_awvalid  = 1'b0;
    s_axil_reg_awaddr   = '0;
    s_axil_reg_wvalid   = 1'b0;
    s_axil_reg_wdata    = '0;
    s_axil_reg_bready   = 1'b0;
    s_axil_reg_arvalid  = 1'b0;
    s_axil_reg_araddr   = '0;
    s_axil_reg_rready   = 1'b0;
    roce_pkt_recved     = 1'b0;
    non_roce_pkt_recved = 1'b0;
    fatal_err           = '0;
    mismatch_count      = 0;
    failure_count       = 0;
    lfsr                = LFSR_SEED;
    exp_clr[0]          = '0;
    exp_clr[1]          = '0;
    exp_total[0]        = '0;
    exp_total[1]        = '0;
    exp_template        = '0;
    exp_fatal           = '0;
    repeat (RESET_CYCLES) @(posedge axil_aclk);
    #DRIVE_DELAY;
    axil_arstn = 1'b1;

    test_reset_and_fixed();
    test_template();
    test_pkt_counting();
    test_clear_on_read();
    test_fatal_err();
    test_back_pressure();

    failure_count += u_rn_reg_control.u_chk.assert_failures;
    $display("Value mismatches: %0d, other errors: %0d", mismatch_count, failure_count);
    if (mismatch_count + failure_count == 0)
    begin
      $display("All tests passed!");
    end
    else
    begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+include
hdl/rn_reg_pkg.sv
hdl/reg_access_if.sv
hdl/axil_reg_slave.sv
hdl/pkt_stats.sv
hdl/reg_file.sv
hdl/rn_reg_control.sv
test/rn_reg_control_chk.sv
test/tb_rn_reg_control.sv
